// File: logic/ising_pkg.sv
// ####################
// Ising machine shared definitions
// Sizes, payload types and register map
// ####################

package ising_pkg;

    // ####################
    // Problem size
    // ####################
    localparam int N         = 3;                 // Spins
    localparam int NUM_PAIRS = N * (N - 1) / 2;   // Couplings, one per spin pair

    localparam int WEIGHT_W = 4;
    localparam int BIAS_W   = 4;
    localparam int FIELD_W  = 8;                  // Room for N-1 couplings plus bias

    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [BIAS_W-1:0]   bias_t;

    // ####################
    // Register map, byte addresses
    // ####################
    localparam logic [31:0] CTR_CUTOFF_ADDR  = 32'h0000_0000;
    localparam logic [31:0] CTR_MAX_ADDR     = 32'h0000_0004;
    localparam logic [31:0] START_ADDR       = 32'h0000_0008;
    localparam logic [31:0] STATUS_ADDR      = 32'h0000_000C;
    localparam logic [31:0] WEIGHT_ADDR_BASE = 32'h0000_0100;  // One word per pair
    localparam logic [31:0] BIAS_ADDR_BASE   = 32'h0000_0200;  // One word per spin
    localparam logic [31:0] PHASE_ADDR_BASE  = 32'h0000_0300;  // One word per spin

    // Bit 0 is spin -1, bit 1 is spin +1
    localparam logic [N-1:0] INIT_PHASE = '0;

    // Flat index of pair (a, b), either order
    // (0,1)=0, (0,2)=1, (1,2)=2 for N=3
    function automatic int pair_index(input int a, input int b);
        int i;
        int j;
        i = (a < b) ? a : b;
        j = (a < b) ? b : a;
        return i * N - i * (i + 1) / 2 + (j - i - 1);
    endfunction

endpackage

// File: logic/weight_store.sv
// ####################
// Problem store
// One payload per word in an address window
// ####################

`timescale 1ns/1ps

module weight_store #(
    parameter type         payload_t = logic [7:0],
    parameter int          DEPTH     = 1,
    parameter logic [31:0] BASE_ADDR = 32'h0
) (
    input  logic        clk,
    input  logic        axi_rstn,

    input  logic        wready,
    input  logic [31:0] wr_addr,
    input  logic [31:0] wdata,

    output payload_t    entries [DEPTH]
);

    logic [31:0] word_off;
    logic        in_window;
    payload_t    wr_val;

    // Window is BASE_ADDR up to BASE_ADDR + 4*DEPTH, end excluded
    assign in_window = (wr_addr >= BASE_ADDR) &&
                       (wr_addr < BASE_ADDR + 32'(4 * DEPTH));

    assign word_off  = (wr_addr - BASE_ADDR) >> 2;

    // Low bits of the data word carry the payload
    assign wr_val    = payload_t'(wdata[$bits(payload_t)-1:0]);

    // ####################
    // Entry registers
    // ####################
    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            for (int k = 0; k < DEPTH; k++) begin
                entries[k] <= '0;
            end
        end else if (wready && in_window) begin
            for (int k = 0; k < DEPTH; k++) begin
                if (word_off == 32'(k)) begin
                    entries[k] <= wr_val;
                end
            end
        end
    end

endmodule

// File: logic/top_ising.sv
// ####################
// Ising annealing core
// Round-robin sign update of one spin per cycle
// ####################

`timescale 1ns/1ps

module top_ising import ising_pkg::*; (
    input  logic         clk,
    input  logic         axi_rstn,
    input  logic         ising_rstn,

    input  logic [31:0]  counter_cutoff,
    input  logic [31:0]  counter_max,

    // Write strobe, passed on to the stores
    input  logic         wready,
    input  logic [31:0]  wr_addr,
    input  logic [31:0]  wdata,

    output logic [N-1:0] phase,
    output logic         done
);

    // ####################
    // Problem stores
    // ####################
    weight_t weights [NUM_PAIRS];
    bias_t   biases  [N];

    weight_store #(
        .payload_t (weight_t),
        .DEPTH     (NUM_PAIRS),
        .BASE_ADDR (WEIGHT_ADDR_BASE)
    ) u_weights (
        .clk      (clk),
        .axi_rstn (axi_rstn),
        .wready   (wready),
        .wr_addr  (wr_addr),
        .wdata    (wdata),
        .entries  (weights)
    );

    weight_store #(
        .payload_t (bias_t),
        .DEPTH     (N),
        .BASE_ADDR (BIAS_ADDR_BASE)
    ) u_biases (
        .clk      (clk),
        .axi_rstn (axi_rstn),
        .wready   (wready),
        .wr_addr  (wr_addr),
        .wdata    (wdata),
        .entries  (biases)
    );

    // ####################
    // Run state
    // ####################
    logic [31:0]          counter;
    logic [$clog2(N)-1:0] rr_idx;      // Tracks counter mod N
    logic                 active;
    logic                 bias_on;

    assign active  = (counter < counter_max);
    assign bias_on = (counter < counter_cutoff);   // Annealing schedule
    assign done    = ising_rstn && !active;

    // ####################
    // Local fields
    // ####################
    logic signed [FIELD_W-1:0] field_all [N];
    logic signed [FIELD_W-1:0] sel_field;
    logic                      new_spin;

    always_comb begin
        logic signed [FIELD_W-1:0] w_ext;
        logic signed [FIELD_W-1:0] b_ext;
        for (int i = 0; i < N; i++) begin
            field_all[i] = '0;
            for (int j = 0; j < N; j++) begin
                if (j != i) begin
                    w_ext = weights[pair_index(i, j)];
                    // Bit 1 is +1, bit 0 is -1
                    if (phase[j]) begin
                        field_all[i] = field_all[i] + w_ext;
                    end else begin
                        field_all[i] = field_all[i] - w_ext;
                    end
                end
            end
            b_ext = biases[i];
            if (bias_on) begin
                field_all[i] = field_all[i] + b_ext;
            end
        end
    end

    assign sel_field = field_all[rr_idx];

    // Zero field keeps the old spin
    always_comb begin
        if (sel_field > 0) begin
            new_spin = 1'b1;
        end else if (sel_field < 0) begin
            new_spin = 1'b0;
        end else begin
            new_spin = phase[rr_idx];
        end
    end

    // ####################
    // Spin update
    // ####################
    always_ff @(posedge clk) begin
        if (!axi_rstn || !ising_rstn) begin
            phase   <= INIT_PHASE;
            counter <= 32'b0;
            rr_idx  <= '0;
        end else if (active) begin
            phase[rr_idx] <= new_spin;
            counter       <= counter + 32'd1;
            if (int'(rr_idx) == N - 1) begin
                rr_idx <= '0;
            end else begin
                rr_idx <= rr_idx + 1'b1;
            end
        end
        // Frozen once counter reaches counter_max
    end

endmodule

// File: logic/ising_axi.sv
// ####################
// Ising machine register front end
// Read port, control registers, annealing core
// ####################

`timescale 1ns/1ps

module ising_axi import ising_pkg::*; (
    input  logic        clk,
    input  logic        axi_rstn,

    // Read port
    input  logic        arvalid_q,
    input  logic [31:0] araddr_q,
    input  logic        rready,
    output logic        rvalid,
    output logic        rresp,
    output logic [31:0] rdata,

    // Write strobe
    input  logic        wready,
    input  logic [31:0] wr_addr,
    input  logic [31:0] wdata
);

    logic [N-1:0] phase;
    logic         done;

    logic [31:0]  counter_cutoff;
    logic [31:0]  counter_max;
    logic         ising_rstn;

    // ####################
    // Read decode
    // ####################
    logic [31:0] phase_off;
    logic        phase_hit;
    logic        phase_bit;
    logic [31:0] rd_word;

    assign phase_off = (araddr_q - PHASE_ADDR_BASE) >> 2;
    assign phase_hit = (araddr_q >= PHASE_ADDR_BASE) &&
                       (araddr_q < PHASE_ADDR_BASE + 32'(4 * N));

    always_comb begin
        phase_bit = 1'b0;
        for (int k = 0; k < N; k++) begin
            if (phase_off == 32'(k)) begin
                phase_bit = phase[k];
            end
        end
    end

    always_comb begin
        if (phase_hit) begin
            rd_word = {31'b0, phase_bit};
        end else if (araddr_q == STATUS_ADDR) begin
            rd_word = {31'b0, done};
        end else begin
            rd_word = 32'b0;       // Unmapped
        end
    end

    // Response holds until taken, new requests ignored meanwhile
    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            rvalid <= 1'b0;
            rresp  <= 1'b0;
            rdata  <= 32'b0;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            rresp  <= 1'b0;
            rdata  <= 32'b0;
        end else if (arvalid_q && !rvalid) begin
            rvalid <= 1'b1;
            rresp  <= 1'b0;
            rdata  <= rd_word;
        end
    end

    // ####################
    // Control registers
    // ####################
    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            counter_cutoff <= 32'b0;
            counter_max    <= 32'b0;
            ising_rstn     <= 1'b0;
        end else if (wready) begin
            if (wr_addr == CTR_CUTOFF_ADDR) begin
                counter_cutoff <= wdata;
            end
            if (wr_addr == CTR_MAX_ADDR) begin
                counter_max <= wdata;
            end
            if (wr_addr == START_ADDR) begin
                ising_rstn <= wdata[0];   // 0 re-arms the core
            end
        end
    end

    // ####################
    // Annealing core
    // ####################
    top_ising u_top_ising (
        .clk            (clk),
        .axi_rstn       (axi_rstn),
        .ising_rstn     (ising_rstn),
        .counter_cutoff (counter_cutoff),
        .counter_max    (counter_max),
        .wready         (wready),
        .wr_addr        (wr_addr),
        .wdata          (wdata),
        .phase          (phase),
        .done           (done)
    );

endmodule

// File: tb/tb_clkgen.sv
// ####################
// Testbench clock and reset
// ####################

`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic axi_rstn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    // Low for two rising edges, released on a falling edge
    initial begin
        axi_rstn = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        axi_rstn = 1'b1;
    end

endmodule

// File: tb/ising_assert.sv
// ####################
// Ising machine assertions
// Read strobes, reset state, frozen spins
// ####################

`timescale 1ns/1ps

module ising_assert import ising_pkg::*; (
    input logic         clk,
    input logic         axi_rstn,
    input logic         arvalid_q,
    input logic         rready,
    input logic         rvalid,
    input logic         rresp,
    input logic [31:0]  rdata,
    input logic         ising_rstn,
    input logic [N-1:0] phase,
    input logic         done
);

    int fail_count;

    initial fail_count = 0;

    reset_idle: assert property (@(posedge clk)
        $rose(axi_rstn) |-> !rvalid && !rresp && rdata == 32'b0)
        else begin
            fail_count++;
            $error("read port not idle after reset");
        end

    // ####################
    // Read strobes
    // ####################
    accept_to_valid: assert property (@(posedge clk) disable iff (!axi_rstn)
        arvalid_q && !rvalid |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid missing after accepted request");
        end

    no_request_no_valid: assert property (@(posedge clk) disable iff (!axi_rstn)
        !arvalid_q && !rvalid |=> !rvalid)
        else begin
            fail_count++;
            $error("rvalid rose without a request");
        end

    hold_until_taken: assert property (@(posedge clk) disable iff (!axi_rstn)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            fail_count++;
            $error("read response dropped or changed");
        end

    clear_after_taken: assert property (@(posedge clk) disable iff (!axi_rstn)
        rvalid && rready |=> !rvalid)
        else begin
            fail_count++;
            $error("rvalid still high after rready");
        end

    resp_okay: assert property (@(posedge clk) disable iff (!axi_rstn) !rresp)
        else begin
            fail_count++;
            $error("rresp not zero");
        end

    // ####################
    // Core state
    // ####################
    held_init: assert property (@(posedge clk) disable iff (!axi_rstn)
        !ising_rstn |=> phase == INIT_PHASE)
        else begin
            fail_count++;
            $error("spins not at initial value while held");
        end

    frozen: assert property (@(posedge clk) disable iff (!axi_rstn)
        done |=> !ising_rstn || $stable(phase))
        else begin
            fail_count++;
            $error("spins changed after done");
        end

endmodule

// File: tb/tb_ising.sv
// ####################
// Ising machine testbench
// Loads problems, anneals, checks readback against a model
// ####################

`timescale 1ns/1ps

module tb_ising import ising_pkg::*; ();

    localparam int RUN_FERRO = 9;
    localparam int RUN_MIXED = 12;
    localparam int WATCHDOG_CYCLES = RUN_FERRO + 2 * RUN_MIXED + 200 * 5;   // Five cases

    logic        clk;
    logic        axi_rstn;
    logic        arvalid_q;
    logic [31:0] araddr_q;
    logic        rready;
    logic        rvalid;
    logic        rresp;
    logic [31:0] rdata;
    logic        wready;
    logic [31:0] wr_addr;
    logic [31:0] wdata;

    int seed = 32'h3658;
    int errors = 0;
    int jmat [N][N];      // Symmetric couplings
    int bias_val [N];

    tb_clkgen u_clkgen (.clk(clk), .axi_rstn(axi_rstn));

    ising_axi u_dut (
        .clk(clk), .axi_rstn(axi_rstn),
        .arvalid_q(arvalid_q), .araddr_q(araddr_q), .rready(rready),
        .rvalid(rvalid), .rresp(rresp), .rdata(rdata),
        .wready(wready), .wr_addr(wr_addr), .wdata(wdata)
    );

    bind ising_axi ising_assert u_ising_assert (
        .clk(clk), .axi_rstn(axi_rstn), .arvalid_q(arvalid_q), .rready(rready),
        .rvalid(rvalid), .rresp(rresp), .rdata(rdata),
        .ising_rstn(ising_rstn), .phase(phase), .done(done)
    );

    // ####################
    // Bus tasks
    // ####################
    task automatic idle_gap();
        int n;
        n = $random(seed) & 3;
        repeat (n) @(negedge clk);
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        wready  = 1'b1;
        wr_addr = addr;
        wdata   = data;
        @(negedge clk);
        wready  = 1'b0;
        idle_gap();
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        int delay;
        @(negedge clk);
        arvalid_q = 1'b1;
        araddr_q  = addr;
        @(negedge clk);
        arvalid_q = 1'b0;
        while (!rvalid) @(negedge clk);
        data  = rdata;
        delay = $random(seed) & 3;    // Random back-pressure
        repeat (delay) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        idle_gap();
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // ####################
    // Problem and model
    // ####################
    task automatic load_problem();
        int idx;
        idx = 0;
        for (int i = 0; i < N; i++) begin
            for (int j = i + 1; j < N; j++) begin
                write_reg(WEIGHT_ADDR_BASE + 32'(4 * idx), 32'(jmat[i][j]));
                idx++;
            end
        end
        for (int i = 0; i < N; i++) begin
            write_reg(BIAS_ADDR_BASE + 32'(4 * i), 32'(bias_val[i]));
        end
    endtask

    // Sign update replayed one spin per step with bias before the cutoff
    function automatic logic [N-1:0] predict_spins(input int cutoff, input int steps);
        int s [N];
        int f;
        int i;
        logic [N-1:0] result;
        for (int k = 0; k < N; k++) s[k] = INIT_PHASE[k] ? 1 : -1;
        for (int t = 0; t < steps; t++) begin
            i = t % N;
            f = (t < cutoff) ? bias_val[i] : 0;
            for (int j = 0; j < N; j++) begin
                if (j != i) f += jmat[i][j] * s[j];
            end
            if (f > 0) s[i] = 1;
            else if (f < 0) s[i] = -1;
        end
        for (int k = 0; k < N; k++) result[k] = (s[k] > 0);
        return result;
    endfunction

    task automatic start_run(input int cutoff, input int steps);
        write_reg(START_ADDR, 32'd0);      // Re-arm
        write_reg(CTR_CUTOFF_ADDR, 32'(cutoff));
        write_reg(CTR_MAX_ADDR, 32'(steps));
        write_reg(START_ADDR, 32'd1);
    endtask

    task automatic wait_done();
        logic [31:0] word;
        word = 32'd0;
        while (word[0] !== 1'b1) read_reg(STATUS_ADDR, word);
        check_word("status", word, 32'd1);
    endtask

    task automatic check_spins(input logic [N-1:0] exp, output logic [N-1:0] got);
        logic [31:0] word;
        for (int k = 0; k < N; k++) begin
            read_reg(PHASE_ADDR_BASE + 32'(4 * k), word);
            check_word($sformatf("spin %0d", k), word, {31'b0, exp[k]});
            got[k] = word[0];
        end
    endtask

    // ####################
    // Watchdog
    // ####################
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [N-1:0] got;
        logic [31:0]  word;
        arvalid_q = 1'b0;
        araddr_q  = 32'b0;
        rready    = 1'b0;
        wready    = 1'b0;
        wr_addr   = 32'b0;
        wdata     = 32'b0;
        @(posedge axi_rstn);
        @(negedge clk);

        // Reset state
        check_word("rvalid after reset", {31'b0, rvalid}, 32'd0);
        check_word("rresp after reset", {31'b0, rresp}, 32'd0);
        check_word("rdata after reset", rdata, 32'd0);
        read_reg(STATUS_ADDR, word);
        check_word("status after reset", word, 32'd0);
        check_spins(INIT_PHASE, got);

        // Ferromagnetic problem with a bias that flips the all-down start
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) jmat[i][j] = (i == j) ? 0 : 3;
            bias_val[i] = 7;
        end
        load_problem();
        start_run(3, RUN_FERRO);
        wait_done();
        check_spins(predict_spins(3, RUN_FERRO), got);
        check_word("ferro spins all up", 32'(got), 32'((1 << N) - 1));

        // Mixed signs with the bias of spin 2 cut off before its turn
        jmat[0][1] = -4;
        jmat[1][0] = -4;
        jmat[0][2] = 2;
        jmat[2][0] = 2;
        jmat[1][2] = 1;
        jmat[2][1] = 1;
        bias_val[0] = 5;
        bias_val[1] = -3;
        bias_val[2] = -6;
        load_problem();
        start_run(2, RUN_MIXED);
        wait_done();
        check_spins(predict_spins(2, RUN_MIXED), got);
        check_word("spin 0 xor spin 1", {31'b0, got[0] ^ got[1]}, 32'd1);

        // Store writes after done leave the frozen spins alone
        repeat (20) @(negedge clk);
        write_reg(BIAS_ADDR_BASE, 32'(-8));
        check_spins(predict_spins(2, RUN_MIXED), got);
        write_reg(BIAS_ADDR_BASE, 32'(bias_val[0]));
        start_run(0, 0);
        wait_done();
        check_spins(predict_spins(0, 0), got);

        // Unmapped reads and out-of-window writes
        read_reg(32'h0000_0010, word);
        check_word("unmapped 0x010", word, 32'd0);
        read_reg(32'h0000_0400, word);
        check_word("unmapped 0x400", word, 32'd0);
        read_reg(PHASE_ADDR_BASE + 32'(4 * N), word);
        check_word("past phase window", word, 32'd0);
        write_reg(WEIGHT_ADDR_BASE + 32'(4 * NUM_PAIRS), 32'd7);
        write_reg(BIAS_ADDR_BASE + 32'(4 * N), 32'd7);
        write_reg(BIAS_ADDR_BASE - 32'd4, 32'd7);
        // Same low address bits as live entries
        write_reg(WEIGHT_ADDR_BASE + 32'h1000 + 32'd8, 32'd7);
        write_reg(BIAS_ADDR_BASE + 32'h1000 + 32'd4, 32'd7);
        start_run(2, RUN_MIXED);
        wait_done();
        check_spins(predict_spins(2, RUN_MIXED), got);

        repeat (4) @(negedge clk);
        $display("Errors: %0d readback, %0d assertion", errors,
                 u_dut.u_ising_assert.fail_count);
        if (errors == 0 && u_dut.u_ising_assert.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/ising_pkg.sv
logic/weight_store.sv
logic/top_ising.sv
logic/ising_axi.sv
tb/tb_clkgen.sv
tb/ising_assert.sv
tb/tb_ising.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ising -f filelist.f
	./obj_dir/Vtb_ising +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
